/* Bender.yml */
package:
  name: uart_string_handle

sources:
  - src/uart_string_pkg.sv
  - src/uart_tx.sv
  - src/uart_rx.sv
  - src/string_tx_framer.sv
  - src/string_rx_deframer.sv
  - src/uart_string_handle.sv
  - target: test
    files:
      - tests/uart_string_handle_properties.sv
      - tests/uart_string_handle_tb.sv

/* sources.f */
src/uart_string_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/string_tx_framer.sv
src/string_rx_deframer.sv
src/uart_string_handle.sv
tests/uart_string_handle_properties.sv
tests/uart_string_handle_tb.sv

/* src/string_rx_deframer.sv */
// Finds "&&" content "&&" in the received byte stream.
// A lone '&' in the content is kept; "&&" always closes the frame.
// Frames longer than MAX_BYTES are dropped without rx_done.
// rx_string and rx_length hold the last complete frame, zero-padded.

`timescale 1ns/100ps
`default_nettype none

module string_rx_deframer (
	input  wire                         sys_clk,
	input  wire                         sys_rst_n,
	input  wire uart_string_pkg::byte_t rx_data,
	input  wire                         rx_vld,
	output uart_string_pkg::string_t    rx_string,
	output uart_string_pkg::len_t       rx_length,
	output logic                        rx_busy,
	output logic                        rx_done
);
	import uart_string_pkg::*;

	localparam int IDX_W = $clog2($bits(string_t));

	localparam logic [4:0] RS_IDLE    = 5'b0_0001,
	                       RS_MARK1   = 5'b0_0010, // one opening mark seen
	                       RS_CONTENT = 5'b0_0100,
	                       RS_PEND    = 5'b0_1000, // '&' held back, may close
	                       RS_PUBLISH = 5'b1_0000;

	logic [4:0]       state;
	string_t          work_buf;
	len_t             work_cnt;
	logic             is_mark;
	logic             is_data;
	logic             room1;     // space for one more byte
	logic             room2;     // space for '&' plus one byte
	logic [IDX_W-1:0] slot_lo;
	logic [IDX_W-1:0] slot_hi;

	assign is_mark = rx_vld && (rx_data == FRAME_MARK);
	assign is_data = rx_vld && (rx_data != FRAME_MARK);
	assign room1   = (work_cnt < MAX_BYTES);
	assign room2   = (work_cnt < MAX_BYTES - 1);
	assign slot_lo = {work_cnt[6:0], 3'b000};
	assign slot_hi = slot_lo + IDX_W'(8);

	assign rx_busy = (state != RS_IDLE);
	assign rx_done = (state == RS_PUBLISH);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= RS_IDLE;
			work_cnt <= '0;
		end else begin
			case (state)
				RS_IDLE: if (is_mark)
					state <= RS_MARK1;
				RS_MARK1: begin
					if (is_mark) begin
						state    <= RS_CONTENT;
						work_cnt <= '0;
					end else if (is_data) begin
						state <= RS_IDLE;
					end
				end
				RS_CONTENT: begin
					if (is_mark)
						state <= RS_PEND;
					else if (is_data && room1)
						work_cnt <= work_cnt + 1'b1;
					else if (is_data)
						state <= RS_IDLE; // too long, drop frame
				end
				RS_PEND: begin
					if (is_mark) begin
						state <= RS_PUBLISH;
					end else if (is_data && room2) begin
						work_cnt <= work_cnt + 8'd2;
						state    <= RS_CONTENT;
					end else if (is_data) begin
						state <= RS_IDLE;
					end
				end
				RS_PUBLISH: state <= RS_IDLE;
				default:    state <= RS_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == RS_MARK1 && is_mark) begin
			work_buf <= '0; // unused bytes read back as zero
		end else if (state == RS_CONTENT && is_data && room1) begin
			work_buf[slot_lo +: 8] <= rx_data;
		end else if (state == RS_PEND && is_data && room2) begin
			work_buf[slot_lo +: 8] <= FRAME_MARK;
			work_buf[slot_hi +: 8] <= rx_data;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_string <= '0;
			rx_length <= '0;
		end else if (state == RS_PEND && is_mark) begin
			rx_string <= work_buf; // visible together with rx_done
			rx_length <= work_cnt;
		end
	end

endmodule

`default_nettype wire

/* src/string_tx_framer.sv */
// Sends tx_string as "&&" + content + "&&" through uart_tx.
// tx_req is taken only while idle; string and length are captured then.
// A length of zero sends just the four marks. Lengths above MAX_BYTES
// are not checked.

`timescale 1ns/100ps
`default_nettype none

module string_tx_framer (
	input  wire                           sys_clk,
	input  wire                           sys_rst_n,
	input  wire uart_string_pkg::string_t tx_string,
	input  wire uart_string_pkg::len_t    tx_length,
	input  wire                           tx_req,
	output logic                          tx_busy,
	output logic                          tx_done,
	output uart_string_pkg::byte_t        byte_data,
	output logic                          byte_req,
	input  wire                           byte_done
);
	import uart_string_pkg::*;

	localparam logic [6:0] ST_IDLE    = 7'b000_0001,
	                       ST_MARK1   = 7'b000_0010, // sending opening marks
	                       ST_MARK2   = 7'b000_0100,
	                       ST_CONTENT = 7'b000_1000,
	                       ST_MARK3   = 7'b001_0000, // sending closing marks
	                       ST_MARK4   = 7'b010_0000,
	                       ST_FINISH  = 7'b100_0000;

	logic [6:0] state;
	string_t    str_q;
	len_t       len_q;
	len_t       byte_cnt;      // next content byte to send
	byte_t      cur_byte;
	logic       take_req;
	logic       no_content;
	logic       last_byte;
	logic       load_mark;
	logic       load_content;

	assign tx_busy    = (state != ST_IDLE);
	assign tx_done    = (state == ST_FINISH);
	assign take_req   = (state == ST_IDLE) && tx_req;
	assign no_content = (len_q == '0);
	assign last_byte  = (byte_cnt == len_q);
	assign cur_byte   = str_q[{byte_cnt[6:0], 3'b000} +: 8];

	assign load_content = byte_done &&
		((state == ST_MARK2 && !no_content) || (state == ST_CONTENT && !last_byte));

	assign load_mark = take_req || (byte_done &&
		(state == ST_MARK1 || state == ST_MARK3 ||
		 (state == ST_MARK2 && no_content) || (state == ST_CONTENT && last_byte)));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= ST_IDLE;
			byte_req <= 1'b0;
			byte_cnt <= '0;
			len_q    <= '0;
		end else begin
			byte_req <= load_mark || load_content; // uart_tx is idle by now
			if (take_req) begin
				len_q    <= tx_length;
				byte_cnt <= '0;
			end else if (load_content) begin
				byte_cnt <= byte_cnt + 1'b1;
			end

			case (state)
				ST_IDLE:    if (tx_req) state <= ST_MARK1;
				ST_MARK1:   if (byte_done) state <= ST_MARK2;
				ST_MARK2:   if (byte_done) state <= no_content ? ST_MARK3 : ST_CONTENT;
				ST_CONTENT: if (byte_done && last_byte) state <= ST_MARK3;
				ST_MARK3:   if (byte_done) state <= ST_MARK4;
				ST_MARK4:   if (byte_done) state <= ST_FINISH;
				ST_FINISH:  state <= ST_IDLE;
				default:    state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (take_req)
			str_q <= tx_string;
		if (load_mark)
			byte_data <= FRAME_MARK;
		else if (load_content)
			byte_data <= cur_byte;
	end

endmodule

`default_nettype wire

/* src/uart_rx.sv */
// 8N1 receiver with a two-flop synchronizer on rx.
// Bits are sampled at their middle; CLK_FREQ / BAUD_RATE must be at least 4.
// A byte whose stop bit reads low is dropped, and the receiver then
// waits for the line to go high before hunting for the next start bit.

`timescale 1ns/100ps
`default_nettype none

module uart_rx #(
	parameter int CLK_FREQ  = 50_000_000,
	parameter int BAUD_RATE = 115_200
) (
	input  wire                  sys_clk,
	input  wire                  sys_rst_n,
	input  wire                  rx,
	output uart_string_pkg::byte_t rx_data,
	output logic                 rx_vld
);
	import uart_string_pkg::*;

	localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
	localparam int CNT_W        = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(CLKS_PER_BIT / 2 - 1);

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP,
		RX_WAIT
	} rx_state_t;

	rx_state_t        state;
	logic             rx_meta;
	logic             rx_sync;
	logic             rx_prev;   // for edge detect
	logic             fall;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0]       bit_cnt;
	byte_t            shreg;     // LSB arrives first, enters at the top
	logic             bit_end;

	assign fall    = rx_prev && !rx_sync;
	assign bit_end = (clk_cnt == CNT_LAST);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= RX_IDLE;
			clk_cnt <= '0;
			bit_cnt <= '0;
			rx_vld  <= 1'b0;
		end else begin
			rx_vld <= 1'b0;
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					bit_cnt <= '0;
					if (fall)
						state <= RX_START;
				end
				RX_START: begin
					if (clk_cnt == CNT_HALF) begin
						clk_cnt <= '0;
						state   <= rx_sync ? RX_IDLE : RX_DATA; // glitch rejected
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
					if (bit_end) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= RX_STOP;
					end
				end
				RX_STOP: begin
					clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
					if (bit_end) begin
						rx_vld <= rx_sync;
						state  <= rx_sync ? RX_IDLE : RX_WAIT; // framing error
					end
				end
				RX_WAIT: if (rx_sync)
					state <= RX_IDLE;
				default: state <= RX_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == RX_DATA && bit_end)
			shreg <= {rx_sync, shreg[7:1]};
		if (state == RX_STOP && bit_end && rx_sync)
			rx_data <= shreg; // valid with rx_vld
	end

endmodule

`default_nettype wire

/* src/uart_string_handle.sv */
// String transceiver over one 8N1 UART link, frame "&&" content "&&".
// Content is at most MAX_BYTES bytes and must not contain "&&" or end in '&'.
// CLK_FREQ / BAUD_RATE must be at least 4.
// No back-pressure on receive; a new frame replaces the published one.

`timescale 1ns/100ps
`default_nettype none

module uart_string_handle #(
	parameter int CLK_FREQ  = 50_000_000,
	parameter int BAUD_RATE = 115_200
) (
	input  wire                           sys_clk,
	input  wire                           sys_rst_n,

	input  wire uart_string_pkg::string_t tx_string,
	input  wire uart_string_pkg::len_t    tx_length,
	input  wire                           tx_req,
	output logic                          tx_busy,
	output logic                          tx_done,

	output uart_string_pkg::string_t      rx_string,
	output uart_string_pkg::len_t         rx_length,
	output logic                          rx_busy,
	output logic                          rx_done,

	input  wire                           uart_rx_port,
	output logic                          uart_tx_port
);
	import uart_string_pkg::*;

	byte_t byte_data;  // framer to transmitter
	logic  byte_req;
	logic  byte_done;
	byte_t rx_data;    // receiver to deframer
	logic  rx_vld;

	string_tx_framer u_framer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_string (tx_string),
		.tx_length (tx_length),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.byte_data (byte_data),
		.byte_req  (byte_req),
		.byte_done (byte_done)
	);

	uart_tx #(
		.CLK_FREQ  (CLK_FREQ),
		.BAUD_RATE (BAUD_RATE)
	) u_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_data (byte_data),
		.byte_req  (byte_req),
		.tx        (uart_tx_port),
		.byte_done (byte_done)
	);

	uart_rx #(
		.CLK_FREQ  (CLK_FREQ),
		.BAUD_RATE (BAUD_RATE)
	) u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (uart_rx_port),
		.rx_data   (rx_data),
		.rx_vld    (rx_vld)
	);

	string_rx_deframer u_deframer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_data   (rx_data),
		.rx_vld    (rx_vld),
		.rx_string (rx_string),
		.rx_length (rx_length),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done)
	);

endmodule

`default_nettype wire

/* src/uart_string_pkg.sv */
// Shared types and constants for the string link.
// Strings are packed with byte 0 in the low bits.
// The frame mark '&' cannot appear twice in a row inside content.
// A content length of MAX_BYTES is the largest a frame may carry.

`default_nettype none

package uart_string_pkg;

	// largest content length, fixed by the frame format
	localparam int MAX_BYTES = 128;

	// one serial character
	typedef logic [7:0] byte_t;

	// content length 0 .. MAX_BYTES
	typedef logic [7:0] len_t;

	// byte k sits in bits 8k+7 : 8k
	typedef logic [MAX_BYTES*8-1:0] string_t;

	// delimiter, sent twice before and twice after the content
	localparam byte_t FRAME_MARK = 8'h26; // '&'

endpackage

`default_nettype wire

/* src/uart_tx.sv */
// 8N1 transmitter, LSB first, line idles high.
// CLK_FREQ / BAUD_RATE is truncated to whole clocks and must be at least 4.
// byte_req is only honoured while idle; byte_done marks the last stop-bit cycle.

`timescale 1ns/100ps
`default_nettype none

module uart_tx #(
	parameter int CLK_FREQ  = 50_000_000,
	parameter int BAUD_RATE = 115_200
) (
	input  wire                         sys_clk,
	input  wire                         sys_rst_n,
	input  wire uart_string_pkg::byte_t byte_data,
	input  wire                         byte_req,
	output logic                        tx,
	output logic                        byte_done
);
	import uart_string_pkg::*;

	localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
	localparam int CNT_W        = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

	tx_state_t        state;
	logic [CNT_W-1:0] clk_cnt;  // clocks within the current bit
	logic [2:0]       bit_cnt;  // data bit index
	byte_t            shreg;    // shifts right, bit 0 goes out next
	logic             bit_end;

	assign bit_end   = (clk_cnt == CNT_LAST);
	assign byte_done = (state == TX_STOP) && bit_end;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= TX_IDLE;
			clk_cnt <= '0;
			bit_cnt <= '0;
			tx      <= 1'b1;
		end else begin
			if (state == TX_IDLE || bit_end)
				clk_cnt <= '0;
			else
				clk_cnt <= clk_cnt + 1'b1;

			case (state)
				TX_IDLE: begin
					bit_cnt <= '0;
					if (byte_req) begin
						tx    <= 1'b0; // start bit
						state <= TX_START;
					end
				end
				TX_START: if (bit_end) begin
					tx    <= shreg[0];
					state <= TX_DATA;
				end
				TX_DATA: if (bit_end) begin
					if (bit_cnt == 3'd7) begin
						tx    <= 1'b1; // stop bit
						state <= TX_STOP;
					end else begin
						tx      <= shreg[0];
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				TX_STOP: if (bit_end)
					state <= TX_IDLE;
				default: state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == TX_IDLE && byte_req)
			shreg <= byte_data;
		else if (bit_end && (state == TX_START || state == TX_DATA))
			shreg <= shreg >> 1;
	end

endmodule

`default_nettype wire

/* tests/uart_string_handle_properties.sv */
// Concurrent checks on the top-level strobes, tx_busy and the serial output.
// Bound into uart_string_handle; assertions are off while reset is low.

`timescale 1ns/100ps
`default_nettype none

module uart_string_handle_properties (
	input wire                        sys_clk,
	input wire                        sys_rst_n,
	input wire                        tx_busy,
	input wire                        tx_done,
	input wire                        rx_done,
	input wire                        uart_tx_port,
	input wire uart_string_pkg::len_t rx_length
);
	import uart_string_pkg::*;

	tx_done_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |=> !tx_done) else $error("tx_done high for two cycles");

	rx_done_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_done |=> !rx_done) else $error("rx_done high for two cycles");

	// busy ends only right after the done pulse
	busy_falls_after_done: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$fell(tx_busy) |-> $past(tx_done)) else $error("tx_busy fell without tx_done");

	line_idle_high: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!tx_busy |-> uart_tx_port) else $error("uart_tx_port low while idle");

	length_in_range: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_length <= MAX_BYTES) else $error("rx_length above MAX_BYTES");

endmodule

`default_nettype wire

/* tests/uart_string_handle_tb.sv */
// Testbench for uart_string_handle at 10 clocks per bit.
// Loopback covers framer and deframer together; a bit-level driver
// puts noise and a framing error on the receive line.
// Test content never holds "&&" and never ends in '&'.

`timescale 1ns/100ps
`default_nettype none

module uart_string_handle_tb;
	import uart_string_pkg::*;

	localparam int CLK_FREQ     = 250_000_000;
	localparam int BAUD_RATE    = 25_000_000;
	localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
	localparam int NUM_RAND     = 20;
	localparam int NOISE_BYTES  = 6;

	typedef byte_t byte_q_t[$];

	logic    sys_clk = 1'b0;
	logic    sys_rst_n;
	string_t tx_string;
	len_t    tx_length;
	logic    tx_req;
	logic    tx_busy;
	logic    tx_done;
	string_t rx_string;
	len_t    rx_length;
	logic    rx_busy;
	logic    rx_done;
	logic    uart_rx_port;
	logic    uart_tx_port;
	logic    loop_sel;  // 1 loops tx back to rx
	logic    drv_line;  // bit-level driver output

	string_t exp_string;
	len_t    exp_length;
	logic    pending;
	int      frame_cnt = 0;
	int      req_cnt = 0;
	int      rx_done_cnt = 0;
	int      tx_done_cnt = 0;
	int      cycle_cnt = 0;
	int      limit_cycles;

	assign uart_rx_port = loop_sel ? uart_tx_port : drv_line;

	uart_string_handle #(
		.CLK_FREQ  (CLK_FREQ),
		.BAUD_RATE (BAUD_RATE)
	) dut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	bind uart_string_handle uart_string_handle_properties u_props (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_done      (rx_done),
		.uart_tx_port (uart_tx_port),
		.rx_length    (rx_length)
	);

	always #2 sys_clk = ~sys_clk;

	task automatic stop_with_failure();
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_string(input string name, input string_t got, input string_t exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_length(input string name, input len_t got, input len_t exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	// printable, never the mark
	function automatic byte_t rand_char();
		byte_t c;
		c = FRAME_MARK;
		while (c == FRAME_MARK)
			c = byte_t'(8'h20 + $urandom % 95);
		return c;
	endfunction

	function automatic string_t rand_string(input len_t n);
		string_t s;
		s = '0;
		for (int k = 0; k < n; k++)
			s[8*k +: 8] = rand_char();
		return s;
	endfunction

	function automatic byte_q_t framed_bytes(input string_t s, input len_t n);
		byte_q_t q;
		q = {FRAME_MARK, FRAME_MARK};
		for (int k = 0; k < n; k++)
			q.push_back(s[8*k +: 8]);
		q.push_back(FRAME_MARK);
		q.push_back(FRAME_MARK);
		return q;
	endfunction

	// frames found in a byte stream; s and n give the last one
	function automatic int expected_frame(input byte_q_t seq, output string_t s,
	                                      output len_t n);
		int      st;    // 0 idle, 1 one mark, 2 content, 3 mark pending
		int      cnt;
		int      frames;
		string_t work;
		st     = 0;
		cnt    = 0;
		frames = 0;
		work   = '0;
		s      = '0;
		n      = '0;
		foreach (seq[i]) begin
			case (st)
				0: if (seq[i] == FRAME_MARK) st = 1;
				1: begin
					st   = (seq[i] == FRAME_MARK) ? 2 : 0;
					work = '0;
					cnt  = 0;
				end
				2: begin
					if (seq[i] == FRAME_MARK) begin
						st = 3;
					end else if (cnt < MAX_BYTES) begin
						work[8*cnt +: 8] = seq[i];
						cnt++;
					end else begin
						st = 0; // overlong frame dropped
					end
				end
				default: begin
					if (seq[i] == FRAME_MARK) begin
						s = work;
						n = len_t'(cnt);
						frames++;
						st = 0;
					end else if (cnt < MAX_BYTES - 1) begin
						work[8*cnt +: 8]     = FRAME_MARK; // lone mark is data
						work[8*cnt + 8 +: 8] = seq[i];
						cnt += 2;
						st = 2;
					end else begin
						st = 0;
					end
				end
			endcase
		end
		return frames;
	endfunction

	task automatic set_expected(input byte_q_t seq);
		if (expected_frame(seq, exp_string, exp_length) > 0) begin
			pending = 1'b1;
			frame_cnt++;
		end
	endtask

	task automatic wait_frame();
		while (pending)
			@(negedge sys_clk);
		while (tx_busy)
			@(negedge sys_clk);
	endtask

	// ghost adds an ignored request while the frame is in flight
	task automatic send_loopback(input string_t s, input len_t n, input logic ghost);
		set_expected(framed_bytes(s, n));
		tx_string = s;
		tx_length = n;
		tx_req    = 1'b1;
		@(negedge sys_clk);
		tx_req = 1'b0;
		req_cnt++;
		if (ghost) begin
			repeat (50) @(negedge sys_clk);
			check_bit("tx_busy", tx_busy, 1'b1);
			tx_string = rand_string(5); // captured copy must not change
			tx_length = 5;
			tx_req    = 1'b1;
			@(negedge sys_clk);
			tx_req = 1'b0;
			repeat (250) @(negedge sys_clk); // opening marks received by now
			check_bit("rx_busy", rx_busy, 1'b1);
		end
		wait_frame();
	endtask

	task automatic drive_bit(input logic v);
		drv_line = v;
		repeat (CLKS_PER_BIT) @(negedge sys_clk);
	endtask

	task automatic send_serial_byte(input byte_t b, input logic stop_bit);
		drive_bit(1'b0);
		for (int i = 0; i < 8; i++)
			drive_bit(b[i]);
		drive_bit(stop_bit);
		if (!stop_bit) begin
			drive_bit(1'b1); // let the receiver see the line high again
			drive_bit(1'b1);
		end
	endtask

	// byte at bad_idx goes out with a low stop bit and is not received
	task automatic send_serial(input byte_q_t seq, input int bad_idx);
		byte_q_t line;
		line = {};
		foreach (seq[i])
			if (i != bad_idx)
				line.push_back(seq[i]);
		set_expected(line);
		foreach (seq[i])
			send_serial_byte(seq[i], i != bad_idx);
		wait_frame();
	endtask

	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= limit_cycles) begin
			$display("timeout after %0d cycles, a frame never completed", cycle_cnt);
			stop_with_failure();
		end
	end

	// compare each published frame with the reference
	always @(posedge sys_clk) begin
		if (sys_rst_n && tx_done)
			tx_done_cnt++;
		if (sys_rst_n && rx_done) begin
			rx_done_cnt++;
			if (!pending) begin
				$display("rx_done at %0t ns while no frame was expected", $time);
				stop_with_failure();
			end else begin
				check_string("rx_string", rx_string, exp_string);
				check_length("rx_length", rx_length, exp_length);
				pending = 1'b0;
			end
		end
	end

	initial begin
		string_t s;
		len_t    lens[$];
		byte_q_t q;
		byte_q_t frm;
		int      total;
		void'($urandom(32'hc1af));
		sys_rst_n = 1'b0;
		tx_string = '0;
		tx_length = '0;
		tx_req    = 1'b0;
		loop_sel  = 1'b1;
		drv_line  = 1'b1;
		pending   = 1'b0;

		lens = {len_t'(0), len_t'(1), len_t'(MAX_BYTES)};
		repeat (NUM_RAND)
			lens.push_back(len_t'($urandom % (MAX_BYTES + 1)));
		total = 0;
		foreach (lens[i])
			total += lens[i] + 4;
		total += (3 + 4) + 2 * (10 + 4);              // "a&b", busy frame, ignored request
		total += NOISE_BYTES + 2 + (5 + 4) + (8 + 4); // serial driver tests
		limit_cycles = total * 100 * 12 / 10 + 2000;

		repeat (16) @(negedge sys_clk);
		sys_rst_n = 1'b1;
		@(negedge sys_clk);
		check_bit("tx_busy", tx_busy, 1'b0);
		check_bit("tx_done", tx_done, 1'b0);
		check_bit("rx_busy", rx_busy, 1'b0);
		check_bit("rx_done", rx_done, 1'b0);
		check_bit("uart_tx_port", uart_tx_port, 1'b1);
		check_string("rx_string", rx_string, '0);
		check_length("rx_length", rx_length, '0);

		foreach (lens[i])
			send_loopback(rand_string(lens[i]), lens[i], 1'b0);

		s = '0;
		s[23:0] = {8'h62, FRAME_MARK, 8'h61}; // "a&b"
		send_loopback(s, 3, 1'b0);
		check_length("rx_length", rx_length, 3);

		send_loopback(rand_string(10), 10, 1'b1);
		repeat (1500) @(negedge sys_clk); // room for a wrongly started frame

		loop_sel = 1'b0;
		q = {};
		repeat (NOISE_BYTES)
			q.push_back(rand_char());
		q.push_back(FRAME_MARK);
		q.push_back(byte_t'(8'h61 + $urandom % 26)); // lone mark then a letter
		frm = framed_bytes(rand_string(5), 5);
		foreach (frm[i])
			q.push_back(frm[i]);
		send_serial(q, -1);

		send_serial(framed_bytes(rand_string(8), 8), 2 + 3);
		check_length("rx_length", rx_length, 7);

		repeat (20) @(negedge sys_clk);
		check_bit("rx_busy", rx_busy, 1'b0);
		if (rx_done_cnt != frame_cnt || tx_done_cnt != req_cnt) begin
			$display("done counts wrong: %0d rx_done for %0d frames, %0d tx_done for %0d requests",
			         rx_done_cnt, frame_cnt, tx_done_cnt, req_cnt);
			stop_with_failure();
		end else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

`default_nettype wire
